// ==== serial_bus_top.f ====
design/serial_bus_pkg.sv
design/bus_cmd_regs.sv
design/serial_master.sv
design/serial_interconnect.sv
design/serial_mem_target.sv
design/serial_bus_top.sv
verif/serial_bus_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := serial_bus_tb
FILELIST   := serial_bus_top.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing -j 0
PASS_MSG   := Test completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== verif/serial_bus_tb.sv ====
// ****************************************
// serial bus testbench
// table-driven host transfers checked
// against a per-target memory model
// ****************************************
`timescale 1ns/1ps
`default_nettype none

module serial_bus_tb;
    import serial_bus_pkg::*;

    localparam int MAX_ENTRIES  = 32;
    localparam int BUSY_TIMEOUT = 20;
    localparam int DONE_TIMEOUT = 400;

    logic              clk;
    logic              resetn;
    logic              reg_wr;
    reg_sel_t          reg_sel;
    logic [DATA_W-1:0] reg_wdata;
    logic [DATA_W-1:0] reg_rdata;
    logic              done;

    // stimulus table with expected words taken from the model at run time
    logic [ID_W-1:0]   tbl_target [MAX_ENTRIES];
    logic [ADDR_W-1:0] tbl_addr [MAX_ENTRIES];
    logic              tbl_write [MAX_ENTRIES];
    int                tbl_len [MAX_ENTRIES];
    logic [DATA_W-1:0] tbl_data [MAX_ENTRIES][MAX_BURST];
    logic [DATA_W-1:0] tbl_exp [MAX_ENTRIES][MAX_BURST];
    int                n_entries;

    logic [DATA_W-1:0] model [NUM_TARGETS][ADDR_DEPTH];
    logic [31:0]       rng_state;

    serial_bus_top i_dut (
        .clk       (clk),
        .resetn    (resetn),
        .reg_wr    (reg_wr),
        .reg_sel   (reg_sel),
        .reg_wdata (reg_wdata),
        .reg_rdata (reg_rdata),
        .done      (done)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // unmapped ids read back as zero
    function automatic logic [DATA_W-1:0] model_word(input logic [ID_W-1:0] t,
                                                     input logic [ADDR_W-1:0] a);
        if (int'(t) >= NUM_TARGETS) begin
            return '0;
        end
        return model[t][a];
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_word(input string name, input logic [DATA_W-1:0] got,
                              input logic [DATA_W-1:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("[FAIL] %0t ns %s: got %h, expected %h",
                                $time, name, got, exp));
        end
    endtask

    task automatic check_status(input logic [1:0] got, input logic [1:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("[FAIL] %0t ns status[1:0]: got %b, expected %b",
                                $time, got, exp));
        end
    endtask

    task automatic reg_write(input reg_sel_t sel, input logic [DATA_W-1:0] data);
        @(negedge clk);
        reg_wr    = 1'b1;
        reg_sel   = sel;
        reg_wdata = data;
        @(negedge clk);
        reg_wr = 1'b0;
    endtask

    // sampled once the combinational reg_rdata has settled
    task automatic reg_read(input reg_sel_t sel, output logic [DATA_W-1:0] data);
        @(negedge clk);
        reg_sel = sel;
        #1;
        data = reg_rdata;
    endtask

    task automatic read_status(output logic [1:0] status);
        logic [DATA_W-1:0] data;
        reg_read(REG_STATUS, data);
        status = data[1:0];
    endtask

    task automatic wait_busy();
        logic [1:0] status;
        int         cycles;
        logic       seen;
        seen   = 1'b0;
        cycles = 0;
        while (!seen && cycles < BUSY_TIMEOUT) begin
            read_status(status);
            if (status[0]) begin
                seen = 1'b1;
            end else begin
                cycles++;
            end
        end
        if (!seen) begin
            abort_run("busy never rose after the start command");
        end
        // start clears the sticky error
        check_status(status, 2'b01);
    endtask

    // start is rewritten every cycle up to done and must be dropped each time
    task automatic restart_until_done();
        int   cycles;
        logic seen;
        seen   = 1'b0;
        cycles = 0;
        while (!seen && cycles < DONE_TIMEOUT) begin
            @(negedge clk);
            if (done) begin
                seen   = 1'b1;
                reg_wr = 1'b0;
            end else begin
                reg_wr    = 1'b1;
                reg_sel   = REG_CTRL;
                reg_wdata = 32'd1;
                cycles++;
            end
        end
        reg_wr = 1'b0;
        if (!seen) begin
            abort_run($sformatf("done never came within %0d cycles", DONE_TIMEOUT));
        end
    endtask

    task automatic add_entry(input logic [ID_W-1:0] t, input logic [ADDR_W-1:0] a,
                             input logic wr, input int len,
                             input logic [DATA_W-1:0] d0, input logic [DATA_W-1:0] d1,
                             input logic [DATA_W-1:0] d2, input logic [DATA_W-1:0] d3);
        tbl_target[n_entries]  = t;
        tbl_addr[n_entries]    = a;
        tbl_write[n_entries]   = wr;
        tbl_len[n_entries]     = len;
        tbl_data[n_entries][0] = d0;
        tbl_data[n_entries][1] = d1;
        tbl_data[n_entries][2] = d2;
        tbl_data[n_entries][3] = d3;
        n_entries++;
    endtask

    task automatic run_transfer(input int i);
        logic [DATA_W-1:0] data;
        logic [1:0]        status;
        logic [ADDR_W-1:0] a;
        logic              exp_err;
        exp_err = (int'(tbl_target[i]) >= NUM_TARGETS);
        reg_write(REG_TARGET, DATA_W'(tbl_target[i]));
        reg_write(REG_ADDR, DATA_W'(tbl_addr[i]));
        reg_write(REG_MODE, DATA_W'({LEN_W'(tbl_len[i] - 1), tbl_write[i]}));
        if (tbl_write[i]) begin
            for (int k = 0; k < tbl_len[i]; k++) begin
                reg_write(reg_sel_t'(REG_WDATA0 + k), tbl_data[i][k]);
            end
        end
        reg_write(REG_CTRL, 32'd1);
        wait_busy();
        // further starts while busy must not begin a second transfer
        restart_until_done();
        read_status(status);
        check_status(status, {exp_err, 1'b0});
        repeat (3) @(negedge clk);
        read_status(status);
        check_status(status, {exp_err, 1'b0});
        for (int k = 0; k < tbl_len[i]; k++) begin
            a = tbl_addr[i] + ADDR_W'(k);
            if (tbl_write[i]) begin
                if (!exp_err) begin
                    model[tbl_target[i]][a] = tbl_data[i][k];
                end
            end else begin
                tbl_exp[i][k] = model_word(tbl_target[i], a);
                reg_read(reg_sel_t'(REG_RDATA0 + k), data);
                check_word($sformatf("reg_rdata (rdata%0d, entry %0d)", k, i),
                           data, tbl_exp[i][k]);
            end
        end
    endtask

    initial begin
        logic [1:0]        status;
        logic [ID_W-1:0]   rt;
        logic [ADDR_W-1:0] ra;
        int                rlen;
        logic [DATA_W-1:0] rd [MAX_BURST];

        resetn    = 1'b0;
        reg_wr    = 1'b0;
        reg_sel   = REG_CTRL;
        reg_wdata = '0;
        n_entries = 0;
        rng_state = 32'hb83c666c;

        // same address on every target, then read back
        add_entry(2'd0, 8'h10, 1'b1, 1, 32'h1111_0000, '0, '0, '0);
        add_entry(2'd1, 8'h10, 1'b1, 1, 32'h2222_0001, '0, '0, '0);
        add_entry(2'd2, 8'h10, 1'b1, 1, 32'h3333_0002, '0, '0, '0);
        add_entry(2'd0, 8'h10, 1'b0, 1, '0, '0, '0, '0);
        add_entry(2'd1, 8'h10, 1'b0, 1, '0, '0, '0, '0);
        add_entry(2'd2, 8'h10, 1'b0, 1, '0, '0, '0, '0);
        // bursts on two targets at one range
        add_entry(2'd1, 8'h40, 1'b1, 4, 32'hcafe_0040, 32'hbeef_0041,
                  32'hf00d_0042, 32'hd00d_0043);
        add_entry(2'd1, 8'h40, 1'b0, 4, '0, '0, '0, '0);
        add_entry(2'd1, 8'h42, 1'b0, 1, '0, '0, '0, '0);
        add_entry(2'd2, 8'h40, 1'b1, 4, 32'h0bad_1040, 32'h0bad_1041,
                  32'h0bad_1042, 32'h0bad_1043);
        add_entry(2'd1, 8'h40, 1'b0, 4, '0, '0, '0, '0);
        add_entry(2'd2, 8'h41, 1'b0, 3, '0, '0, '0, '0);
        // unmapped id, then a mapped one clears the error
        add_entry(2'd3, 8'h40, 1'b0, 4, '0, '0, '0, '0);
        add_entry(2'd0, 8'h10, 1'b0, 1, '0, '0, '0, '0);
        add_entry(2'd3, 8'h10, 1'b1, 1, 32'hdead_dead, '0, '0, '0);
        add_entry(2'd1, 8'h10, 1'b0, 1, '0, '0, '0, '0);

        // random write and read-back pairs
        for (int r = 0; r < 4; r++) begin
            rng_state = lcg_next(rng_state);
            rt        = ID_W'(rng_state[31:24] % NUM_TARGETS);
            ra        = rng_state[23:16];
            rlen      = int'(rng_state[15:14]) + 1;
            for (int k = 0; k < MAX_BURST; k++) begin
                rng_state = lcg_next(rng_state);
                rd[k]     = rng_state;
            end
            add_entry(rt, ra, 1'b1, rlen, rd[0], rd[1], rd[2], rd[3]);
            add_entry(rt, ra, 1'b0, rlen, '0, '0, '0, '0);
        end

        repeat (16) @(negedge clk);
        resetn = 1'b1;
        read_status(status);
        check_status(status, 2'b00);

        for (int i = 0; i < n_entries; i++) begin
            run_transfer(i);
        end

        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// ==== design/serial_bus_top.sv ====
// ****************************************
// serial bus subsystem top
// host registers, master, interconnect and
// three memory targets
// ****************************************
`timescale 1ns/1ps
`default_nettype none

module serial_bus_top (
    input  wire logic                               clk,
    input  wire logic                               resetn,
    input  wire logic                               reg_wr,
    input  wire serial_bus_pkg::reg_sel_t           reg_sel,
    input  wire logic [serial_bus_pkg::DATA_W-1:0]  reg_wdata,
    output logic [serial_bus_pkg::DATA_W-1:0]       reg_rdata,
    output logic                                    done
);
    import serial_bus_pkg::*;

    logic              go;
    logic [ID_W-1:0]   target_id;
    logic [ADDR_W-1:0] start_addr;
    logic              write_en;
    logic [LEN_W-1:0]  burst_len;
    logic [DATA_W-1:0] wbuf_word;
    logic [LEN_W-1:0]  wbuf_idx;
    logic              busy;
    logic              rbuf_we;
    logic [LEN_W-1:0]  rbuf_idx;
    logic [DATA_W-1:0] rbuf_word;
    logic              xfer_done;
    logic              xfer_error;

    // serial bus lines
    logic                   control;
    logic                   wD;
    logic                   valid;
    logic                   last;
    logic                   rD;
    logic                   ready;
    logic                   decode_error;
    logic [NUM_TARGETS-1:0] rD_n;
    logic [NUM_TARGETS-1:0] ready_n;

    bus_cmd_regs i_regs (
        .clk        (clk),
        .resetn     (resetn),
        .reg_wr     (reg_wr),
        .reg_sel    (reg_sel),
        .reg_wdata  (reg_wdata),
        .busy       (busy),
        .rbuf_we    (rbuf_we),
        .rbuf_idx   (rbuf_idx),
        .rbuf_word  (rbuf_word),
        .xfer_done  (xfer_done),
        .xfer_error (xfer_error),
        .reg_rdata  (reg_rdata),
        .go         (go),
        .target_id  (target_id),
        .start_addr (start_addr),
        .write_en   (write_en),
        .burst_len  (burst_len),
        .wbuf_word  (wbuf_word),
        .done       (done),
        .wbuf_idx   (wbuf_idx)
    );

    serial_master i_master (
        .clk          (clk),
        .resetn       (resetn),
        .go           (go),
        .target_id    (target_id),
        .start_addr   (start_addr),
        .write_en     (write_en),
        .burst_len    (burst_len),
        .wbuf_word    (wbuf_word),
        .rD           (rD),
        .ready        (ready),
        .decode_error (decode_error),
        .busy         (busy),
        .wbuf_idx     (wbuf_idx),
        .rbuf_we      (rbuf_we),
        .rbuf_idx     (rbuf_idx),
        .rbuf_word    (rbuf_word),
        .xfer_done    (xfer_done),
        .xfer_error   (xfer_error),
        .control      (control),
        .wD           (wD),
        .valid        (valid),
        .last         (last)
    );

    serial_interconnect i_interconnect (
        .clk          (clk),
        .resetn       (resetn),
        .control      (control),
        .rD_n         (rD_n),
        .ready_n      (ready_n),
        .rD           (rD),
        .ready        (ready),
        .decode_error (decode_error)
    );

    // one target per mapped id
    for (genvar i = 0; i < NUM_TARGETS; i++) begin : g_target
        serial_mem_target #(
            .TARGET_ID (i)
        ) i_target (
            .clk     (clk),
            .resetn  (resetn),
            .control (control),
            .wD      (wD),
            .valid   (valid),
            .last    (last),
            .rD      (rD_n[i]),
            .ready   (ready_n[i])
        );
    end

endmodule

`default_nettype wire

// ==== design/serial_mem_target.sv ====
// ****************************************
// serial memory target
// decodes frames for its own id and runs
// single or burst word reads and writes
// ****************************************
`timescale 1ns/1ps
`default_nettype none

module serial_mem_target #(
    parameter int TARGET_ID = 0
) (
    input  wire logic clk,
    input  wire logic resetn,
    input  wire logic control,
    input  wire logic wD,
    input  wire logic valid,
    input  wire logic last,
    output logic      rD,
    output logic      ready
);
    import serial_bus_pkg::*;

    target_state_t      state;
    logic [FCNT_W-1:0]  frame_cnt;
    logic [BCNT_W-1:0]  bit_cnt;
    logic [ADDR_W-1:0]  addr;
    logic               burst;
    logic               wr_pend;
    logic [FRAME_W-1:0] frame_buf;
    logic [DATA_W-1:0]  word_sr;
    logic [DATA_W-1:0]  mem [ADDR_DEPTH];

    logic              hit;
    logic              frame_rw;
    logic              frame_burst;
    logic [ADDR_W-1:0] frame_addr;
    logic              word_end;
    logic              shift_en;
    logic              rd_fetch;

    // frame fields, msb first
    assign frame_rw    = frame_buf[ADDR_W+1];
    assign frame_burst = frame_buf[ADDR_W];
    assign frame_addr  = frame_buf[ADDR_W-1:0];
    assign hit = (state == T_DECODE)
              && (frame_buf[FRAME_W-1 -: 3] == START_PATTERN)
              && (frame_buf[FRAME_W-4 -: ID_W] == ID_W'(TARGET_ID));

    assign word_end = (bit_cnt == BCNT_W'(DATA_W - 1));
    // first write bit arrives together with the decode cycle
    assign shift_en = (state == T_READ)
                   || (valid && (state == T_WRITE || (hit && frame_rw)));
    assign rd_fetch = (hit && !frame_rw)
                   || (state == T_READ && word_end && !last);

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state     <= T_IDLE;
            frame_cnt <= '0;
            bit_cnt   <= '0;
            addr      <= '0;
            burst     <= 1'b0;
            wr_pend   <= 1'b0;
        end else begin
            wr_pend <= (state == T_WRITE) && valid && word_end;
            if (shift_en) begin
                bit_cnt <= bit_cnt + 1'b1;
            end
            case (state)
                T_IDLE: begin
                    if (control) begin
                        frame_cnt <= FCNT_W'(1);
                        state     <= T_FRAME;
                    end
                end
                T_FRAME: begin
                    frame_cnt <= frame_cnt + 1'b1;
                    if (frame_cnt == FCNT_W'(FRAME_W - 1)) begin
                        state <= T_DECODE;
                    end
                end
                T_DECODE: begin
                    if (hit) begin
                        burst <= frame_burst;
                        // reads keep addr one word ahead of the shifter
                        if (frame_rw) begin
                            addr  <= frame_addr;
                            state <= T_WRITE;
                        end else begin
                            addr  <= frame_addr + ADDR_W'(frame_burst);
                            state <= T_READ;
                        end
                    end else begin
                        state <= T_IDLE;
                    end
                end
                T_WRITE: begin
                    if (valid && word_end && last) begin
                        state <= T_DONE;
                    end
                end
                T_READ: begin
                    if (word_end) begin
                        if (last) begin
                            state <= T_DONE;
                        end else begin
                            addr <= addr + ADDR_W'(burst);
                        end
                    end
                end
                T_DONE:  state <= T_IDLE;
                default: state <= T_IDLE;
            endcase
            // completed write word goes to memory this cycle
            if (wr_pend) begin
                addr <= addr + ADDR_W'(burst);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == T_IDLE || state == T_FRAME) begin
            frame_buf <= {frame_buf[FRAME_W-2:0], control};
        end
        if (wr_pend) begin
            mem[addr] <= word_sr;
        end
        if (rd_fetch) begin
            word_sr <= mem[(state == T_DECODE) ? frame_addr : addr];
        end else if (shift_en) begin
            word_sr <= {word_sr[DATA_W-2:0], wD};
        end
    end

    assign rD    = (state == T_READ) && word_sr[DATA_W-1];
    assign ready = !(hit || state == T_READ || state == T_WRITE);

endmodule

`default_nettype wire

// ==== design/serial_interconnect.sv ====
// ****************************************
// serial interconnect
// tracks frames on the control line and
// routes the addressed target's returns
// ****************************************
`timescale 1ns/1ps
`default_nettype none

module serial_interconnect (
    input  wire logic                                 clk,
    input  wire logic                                 resetn,
    input  wire logic                                 control,
    input  wire logic [serial_bus_pkg::NUM_TARGETS-1:0] rD_n,
    input  wire logic [serial_bus_pkg::NUM_TARGETS-1:0] ready_n,
    output logic                                      rD,
    output logic                                      ready,
    output logic                                      decode_error
);
    import serial_bus_pkg::*;

    logic                in_frame;
    logic [FCNT_W-1:0]   frame_cnt;
    logic [FRAME_W-2:0]  frame_sr;
    logic [FRAME_W-1:0]  frame_bits;
    logic [ID_W-1:0]     id_field;
    logic [ID_W-1:0]     sel;

    // whole frame is visible during its last bit
    assign frame_bits = {frame_sr, control};
    assign id_field   = frame_bits[FRAME_W-4 -: ID_W];

    always_ff @(posedge clk) begin
        frame_sr <= frame_bits[FRAME_W-2:0];
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            in_frame     <= 1'b0;
            frame_cnt    <= '0;
            sel          <= '0;
            decode_error <= 1'b0;
        end else begin
            decode_error <= 1'b0;
            if (!in_frame) begin
                in_frame  <= control;
                frame_cnt <= FCNT_W'(1);
            end else begin
                frame_cnt <= frame_cnt + 1'b1;
                if (frame_cnt == FCNT_W'(FRAME_W - 1)) begin
                    in_frame     <= 1'b0;
                    sel          <= id_field;
                    decode_error <= (id_field >= ID_W'(NUM_TARGETS));
                end
            end
        end
    end

    // unmapped id reads as zero data with ready high
    always_comb begin
        rD    = 1'b0;
        ready = 1'b1;
        for (int i = 0; i < NUM_TARGETS; i++) begin
            if (sel == ID_W'(i)) begin
                rD    = rD_n[i];
                ready = ready_n[i];
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/serial_master.sv ====
// ****************************************
// serial bus master
// sends the configuration frame, then write
// data or collects read data, word by word
// ****************************************
`timescale 1ns/1ps
`default_nettype none

module serial_master (
    input  wire logic                               clk,
    input  wire logic                               resetn,
    input  wire logic                               go,
    input  wire logic [serial_bus_pkg::ID_W-1:0]    target_id,
    input  wire logic [serial_bus_pkg::ADDR_W-1:0]  start_addr,
    input  wire logic                               write_en,
    input  wire logic [serial_bus_pkg::LEN_W-1:0]   burst_len,
    input  wire logic [serial_bus_pkg::DATA_W-1:0]  wbuf_word,
    input  wire logic                               rD,
    input  wire logic                               ready,
    input  wire logic                               decode_error,
    output logic                                    busy,
    output logic [serial_bus_pkg::LEN_W-1:0]        wbuf_idx,
    output logic                                    rbuf_we,
    output logic [serial_bus_pkg::LEN_W-1:0]        rbuf_idx,
    output logic [serial_bus_pkg::DATA_W-1:0]       rbuf_word,
    output logic                                    xfer_done,
    output logic                                    xfer_error,
    output logic                                    control,
    output logic                                    wD,
    output logic                                    valid,
    output logic                                    last
);
    import serial_bus_pkg::*;

    master_state_t     state;
    logic [BCNT_W-1:0] bit_cnt;
    logic [LEN_W-1:0]  word_cnt;
    logic [FRAME_W-1:0] frame_sr;
    logic [DATA_W-1:0] word_sr;
    logic [DATA_W-2:0] rword;
    logic              frame_end;
    logic              word_end;
    logic              final_word;

    assign frame_end  = (state == M_FRAME) && (bit_cnt == BCNT_W'(FRAME_W - 1));
    assign word_end   = (bit_cnt == BCNT_W'(DATA_W - 1));
    assign final_word = (word_cnt == burst_len);

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state    <= M_IDLE;
            bit_cnt  <= '0;
            word_cnt <= '0;
        end else begin
            case (state)
                M_IDLE: begin
                    if (go) begin
                        state    <= M_FRAME;
                        bit_cnt  <= '0;
                        word_cnt <= '0;
                    end
                end
                M_FRAME: begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (frame_end) begin
                        bit_cnt <= '0;
                        state   <= write_en ? M_WDATA : M_RGAP;
                    end
                end
                // read data arrives two cycles after the frame
                M_RGAP: state <= M_RDATA;
                M_WDATA, M_RDATA: begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (word_end) begin
                        if (final_word) begin
                            state <= M_WAIT;
                        end else begin
                            word_cnt <= word_cnt + 1'b1;
                        end
                    end
                end
                // target holds ready low until it is finished
                M_WAIT: begin
                    if (ready) begin
                        state <= M_IDLE;
                    end
                end
                default: state <= M_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == M_IDLE && go) begin
            frame_sr <= {START_PATTERN, target_id, write_en, burst_len != '0, start_addr};
        end else if (state == M_FRAME) begin
            frame_sr <= frame_sr << 1;
        end
        if ((frame_end && write_en) || (state == M_WDATA && word_end)) begin
            word_sr <= wbuf_word;
        end else if (state == M_WDATA) begin
            word_sr <= word_sr << 1;
        end
        if (state == M_RDATA) begin
            rword <= rbuf_word[DATA_W-2:0];
        end
    end

    // next word is fetched while the current one shifts out
    assign wbuf_idx = (state == M_WDATA) ? word_cnt + 1'b1 : word_cnt;

    assign control = (state == M_FRAME) && frame_sr[FRAME_W-1];
    assign valid   = (state == M_WDATA);
    assign wD      = valid && word_sr[DATA_W-1];
    assign last    = final_word && ((valid && word_end) || state == M_RDATA);

    assign rbuf_word = {rword, rD};
    assign rbuf_we   = (state == M_RDATA) && word_end;
    assign rbuf_idx  = word_cnt;

    assign busy       = (state != M_IDLE);
    assign xfer_done  = (state == M_WAIT) && ready;
    assign xfer_error = decode_error && busy;

endmodule

`default_nettype wire

// ==== design/bus_cmd_regs.sv ====
// ****************************************
// bus command registers
// host view of the command, write and read
// buffers and status next to the master
// ****************************************
`timescale 1ns/1ps
`default_nettype none

module bus_cmd_regs (
    input  wire logic                               clk,
    input  wire logic                               resetn,
    input  wire logic                               reg_wr,
    input  wire serial_bus_pkg::reg_sel_t           reg_sel,
    input  wire logic [serial_bus_pkg::DATA_W-1:0]  reg_wdata,
    input  wire logic                               busy,
    input  wire logic                               rbuf_we,
    input  wire logic [serial_bus_pkg::LEN_W-1:0]   rbuf_idx,
    input  wire logic [serial_bus_pkg::DATA_W-1:0]  rbuf_word,
    input  wire logic                               xfer_done,
    input  wire logic                               xfer_error,
    output logic [serial_bus_pkg::DATA_W-1:0]       reg_rdata,
    output logic                                    go,
    output logic [serial_bus_pkg::ID_W-1:0]         target_id,
    output logic [serial_bus_pkg::ADDR_W-1:0]       start_addr,
    output logic                                    write_en,
    output logic [serial_bus_pkg::LEN_W-1:0]        burst_len,
    output logic [serial_bus_pkg::DATA_W-1:0]       wbuf_word,
    output logic                                    done,
    input  wire logic [serial_bus_pkg::LEN_W-1:0]   wbuf_idx
);
    import serial_bus_pkg::*;

    logic [DATA_W-1:0] wbuf [MAX_BURST];
    logic [DATA_W-1:0] rbuf [MAX_BURST];
    logic              dec_err;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            go         <= 1'b0;
            done       <= 1'b0;
            dec_err    <= 1'b0;
            target_id  <= '0;
            start_addr <= '0;
            write_en   <= 1'b0;
            burst_len  <= '0;
        end else begin
            go   <= 1'b0;
            done <= xfer_done;
            if (xfer_error) begin
                dec_err <= 1'b1;
            end
            if (reg_wr) begin
                case (reg_sel)
                    // a start while busy is dropped
                    REG_CTRL: begin
                        if (!busy && !go) begin
                            go      <= 1'b1;
                            dec_err <= 1'b0;
                        end
                    end
                    REG_TARGET: target_id <= reg_wdata[ID_W-1:0];
                    REG_ADDR:   start_addr <= reg_wdata[ADDR_W-1:0];
                    // bit 0 write, bits 2:1 length minus one
                    REG_MODE: begin
                        write_en  <= reg_wdata[0];
                        burst_len <= reg_wdata[LEN_W:1];
                    end
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reg_wr && (reg_sel inside {[REG_WDATA0:REG_WDATA3]})) begin
            wbuf[LEN_W'(reg_sel - REG_WDATA0)] <= reg_wdata;
        end
        if (rbuf_we) begin
            rbuf[rbuf_idx] <= rbuf_word;
        end
    end

    assign wbuf_word = wbuf[wbuf_idx];

    always_comb begin
        reg_rdata = '0;
        case (reg_sel)
            REG_TARGET: reg_rdata[ID_W-1:0] = target_id;
            REG_ADDR:   reg_rdata[ADDR_W-1:0] = start_addr;
            REG_MODE:   reg_rdata[LEN_W:0] = {burst_len, write_en};
            REG_WDATA0, REG_WDATA1, REG_WDATA2, REG_WDATA3:
                reg_rdata = wbuf[LEN_W'(reg_sel - REG_WDATA0)];
            REG_RDATA0, REG_RDATA1, REG_RDATA2, REG_RDATA3:
                reg_rdata = rbuf[LEN_W'(reg_sel - REG_RDATA0)];
            REG_STATUS: reg_rdata[1:0] = {dec_err, busy};
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== design/serial_bus_pkg.sv ====
// ****************************************
// serial bus package
// bus widths, frame layout, host register
// selects and the master and target states
// ****************************************
`default_nettype none

package serial_bus_pkg;

    localparam int NUM_TARGETS = 3;
    localparam int ID_W        = 2;
    localparam int DATA_W      = 32;
    localparam int ADDR_DEPTH  = 256;
    localparam int ADDR_W      = 8;
    localparam int MAX_BURST   = 4;
    localparam int LEN_W       = 2;

    // frame: start | id | rw | burst | addr, msb first
    localparam logic [2:0] START_PATTERN = 3'b111;
    localparam int FRAME_W = 3 + ID_W + 2 + ADDR_W;

    // counter widths for frame bits and data bits
    localparam int FCNT_W = $clog2(FRAME_W);
    localparam int BCNT_W = $clog2(DATA_W);

    typedef enum logic [3:0] {
        REG_CTRL   = 4'd0,
        REG_TARGET = 4'd1,
        REG_ADDR   = 4'd2,
        REG_MODE   = 4'd3,
        REG_WDATA0 = 4'd4,
        REG_WDATA1 = 4'd5,
        REG_WDATA2 = 4'd6,
        REG_WDATA3 = 4'd7,
        REG_RDATA0 = 4'd8,
        REG_RDATA1 = 4'd9,
        REG_RDATA2 = 4'd10,
        REG_RDATA3 = 4'd11,
        REG_STATUS = 4'd12
    } reg_sel_t;

    typedef enum logic [2:0] {
        M_IDLE, M_FRAME, M_WDATA, M_RGAP, M_RDATA, M_WAIT
    } master_state_t;

    typedef enum logic [2:0] {
        T_IDLE, T_FRAME, T_DECODE, T_READ, T_WRITE, T_DONE
    } target_state_t;

endpackage

`default_nettype wire
